//--- ddr_bridge.f
+incdir+include
hdl/ddr_bridge_pkg.sv
hdl/wr_upsizer.sv
hdl/reg_slice_chain.sv
hdl/rd_checker.sv
hdl/ddr_status.sv
hdl/ddr_bridge_top.sv
tests/ddr_bridge_checker.sv
tests/tb_ddr_bridge.sv

//--- Makefile
# Verilator simulation of the DDR bridge data path

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f ddr_bridge.f --top-module tb_ddr_bridge -Mdir obj_dir
	./obj_dir/Vtb_ddr_bridge | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- tests/tb_ddr_bridge.sv
//**************************************************************************
// DDR bridge testbench
//**************************************************************************
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module tb_ddr_bridge;
  import ddr_bridge_pkg::*;

  typedef enum logic [1:0] {ROW_IDLE, ROW_WRITE, ROW_READ} row_kind_e;

  // One stimulus row, applied for one clock cycle
  typedef struct packed {
    row_kind_e    kind;
    logic [3:0]   id;
    logic         calib;
    narrow_beat_t beat;
    rd_check_t    rd;
  } stim_row_t;

  logic         c0_ddr4_clk;
  logic         reset_i;
  logic         calib_done_i;
  logic         wr_valid_i;
  narrow_beat_t wr_beat_i;
  logic         rd_valid_i;
  rd_check_t    rd_i;
  logic [3:0]   test_id;
  logic         mem_valid_o;
  wide_word_t   mem_word_o;
  logic         compare_error_o;
  err_cnt_t     err_wr_cnt_o;
  err_cnt_t     err_rd_cnt_o;
  err_cnt_t     err_mm_cnt_o;
  int           errors;
  int           checks;
  int           pending;
  stim_row_t    stim_q[$];
  integer       seed = 71766;
  logic         table_ready = 1'b0;

  ddr_bridge_top dut0 (
    .c0_ddr4_clk     (c0_ddr4_clk),
    .reset_i         (reset_i),
    .calib_done_i    (calib_done_i),
    .wr_valid_i      (wr_valid_i),
    .wr_beat_i       (wr_beat_i),
    .rd_valid_i      (rd_valid_i),
    .rd_i            (rd_i),
    .mem_valid_o     (mem_valid_o),
    .mem_word_o      (mem_word_o),
    .compare_error_o (compare_error_o),
    .err_wr_cnt_o    (err_wr_cnt_o),
    .err_rd_cnt_o    (err_rd_cnt_o),
    .err_mm_cnt_o    (err_mm_cnt_o)
  );

  ddr_bridge_checker u_checker (
    .c0_ddr4_clk     (c0_ddr4_clk),
    .reset_i         (reset_i),
    .test_id_i       (test_id),
    .calib_done_i    (calib_done_i),
    .wr_valid_i      (wr_valid_i),
    .wr_beat_i       (wr_beat_i),
    .rd_valid_i      (rd_valid_i),
    .rd_i            (rd_i),
    .mem_valid_i     (mem_valid_o),
    .mem_word_i      (mem_word_o),
    .compare_error_i (compare_error_o),
    .err_wr_cnt_i    (err_wr_cnt_o),
    .err_rd_cnt_i    (err_rd_cnt_o),
    .err_mm_cnt_i    (err_mm_cnt_o),
    .error_count_o   (errors),
    .check_count_o   (checks),
    .pending_o       (pending)
  );

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #5 c0_ddr4_clk = ~c0_ddr4_clk;
  end

  //************************************************************************
  // Stimulus table
  //************************************************************************
  task automatic add_row(input row_kind_e kind, input logic [3:0] id, input logic calib,
                         input logic last, input logic [7:0] strb, input logic diff);
    stim_row_t r;
    r                = '0;
    r.kind           = kind;
    r.id             = id;
    r.calib          = calib;
    r.beat.data      = {$random(seed), $random(seed)};
    r.beat.strb      = strb;
    r.beat.last      = last;
    r.rd.expected    = {$random(seed), $random(seed), $random(seed), $random(seed)};
    // Force at least one differing bit for a bad read
    r.rd.rdata       = diff ? r.rd.expected ^ {96'h0, $random(seed) | 32'h1} : r.rd.expected;
    stim_q.push_back(r);
  endtask

  task automatic build_table();
    // Before calibration, nothing reaches the controller
    add_row(ROW_WRITE, 4'd1, 1'b0, 1'b0, 8'hff, 1'b0);
    add_row(ROW_READ,  4'd1, 1'b0, 1'b0, 8'h00, 1'b1);
    add_row(ROW_WRITE, 4'd1, 1'b0, 1'b1, 8'hff, 1'b0);
    add_row(ROW_IDLE,  4'd1, 1'b0, 1'b0, 8'h00, 1'b0);
    add_row(ROW_IDLE,  4'd2, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_WRITE, 4'd2, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd2, 1'b1, 1'b1, 8'hf0, 1'b0);
    add_row(ROW_IDLE,  4'd2, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_WRITE, 4'd3, 1'b1, 1'b1, 8'h0f, 1'b0);
    add_row(ROW_IDLE,  4'd3, 1'b1, 1'b0, 8'h00, 1'b0);
    // Three beat burst, the odd last beat goes out alone
    add_row(ROW_WRITE, 4'd3, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd3, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd3, 1'b1, 1'b1, 8'h3c, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b0, 8'ha5, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b0, 8'hff, 1'b0);
    add_row(ROW_WRITE, 4'd4, 1'b1, 1'b1, 8'h81, 1'b0);
    add_row(ROW_READ,  4'd5, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_READ,  4'd5, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_READ,  4'd5, 1'b1, 1'b0, 8'h00, 1'b1);
    add_row(ROW_IDLE,  4'd5, 1'b1, 1'b0, 8'h00, 1'b0);
    add_row(ROW_READ,  4'd5, 1'b1, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic apply_row(input stim_row_t r);
    test_id      = r.id;
    calib_done_i = r.calib;
    wr_valid_i   = (r.kind == ROW_WRITE);
    wr_beat_i    = r.beat;
    rd_valid_i   = (r.kind == ROW_READ);
    rd_i         = r.rd;
  endtask

  initial begin
    reset_i      = 1'b1;
    test_id      = 4'd0;
    calib_done_i = 1'b0;
    wr_valid_i   = 1'b0;
    wr_beat_i    = '0;
    rd_valid_i   = 1'b0;
    rd_i         = '0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge c0_ddr4_clk);
    #1;
    reset_i = 1'b0;
    foreach (stim_q[i]) begin
      apply_row(stim_q[i]);
      @(posedge c0_ddr4_clk);
      #1;
    end
    test_id    = 4'd0;
    wr_valid_i = 1'b0;
    rd_valid_i = 1'b0;
    // Drain the slice chain, then let the status settle
    @(negedge c0_ddr4_clk);
    wait (pending == 0);
    repeat (3) @(posedge c0_ddr4_clk);
    #1;
    // Only reset clears the sticky error and the counters
    reset_i = 1'b1;
    repeat (3) @(posedge c0_ddr4_clk);
    #1;
    reset_i = 1'b0;
    repeat (3) @(negedge c0_ddr4_clk);
    #1;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    #((stim_q.size() + `DDR_SLICE_DEPTH + 20) * 10);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- tests/ddr_bridge_checker.sv
//**************************************************************************
// DDR bridge result checker
//**************************************************************************
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module ddr_bridge_checker (
  input  logic                         c0_ddr4_clk,
  input  logic                         reset_i,
  input  logic [3:0]                   test_id_i,
  input  logic                         calib_done_i,
  input  logic                         wr_valid_i,
  input  ddr_bridge_pkg::narrow_beat_t wr_beat_i,
  input  logic                         rd_valid_i,
  input  ddr_bridge_pkg::rd_check_t    rd_i,
  input  logic                         mem_valid_i,
  input  ddr_bridge_pkg::wide_word_t   mem_word_i,
  input  logic                         compare_error_i,
  input  ddr_bridge_pkg::err_cnt_t     err_wr_cnt_i,
  input  ddr_bridge_pkg::err_cnt_t     err_rd_cnt_i,
  input  ddr_bridge_pkg::err_cnt_t     err_mm_cnt_i,
  output int                           error_count_o,
  output int                           check_count_o,
  output int                           pending_o
);
  import ddr_bridge_pkg::*;

  // Expected word with the cycle it should leave the slice chain
  typedef struct packed {
    logic [31:0] due;
    logic [3:0]  id;
    wide_word_t  word;
  } exp_word_t;

  exp_word_t    exp_q[$];
  exp_word_t    ent;
  logic [31:0]  cyc;
  logic         half;
  narrow_beat_t lo;
  // Error events {write, read, mismatch}, one and two cycles old
  logic [2:0]   ev1;
  logic [2:0]   ev2;
  logic [3:0]   id1;
  logic [3:0]   id2;
  logic         exp_cmp;
  err_cnt_t     exp_wr;
  err_cnt_t     exp_rd;
  err_cnt_t     exp_mm;
  int           errors = 0;
  int           checks = 0;
  int           pending = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;
  assign pending_o     = pending;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "early_access";
      4'd2:    return "pair_upsize";
      4'd3:    return "single_last";
      4'd4:    return "back_to_back";
      4'd5:    return "read_check";
      default: return "idle";
    endcase
  endfunction

  task automatic check_val(input string what, input logic [3:0] id,
                           input logic [255:0] exp, input logic [255:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name(id), what, exp, act);
    end
  endtask

  // Outputs are stable at the falling edge, inputs are not yet taken
  always @(negedge c0_ddr4_clk) begin
    if (reset_i) begin
      exp_q.delete();
      cyc     = '0;
      half    = 1'b0;
      ev1     = '0;
      ev2     = '0;
      id1     = '0;
      id2     = '0;
      exp_cmp = 1'b0;
      exp_wr  = '0;
      exp_rd  = '0;
      exp_mm  = '0;
    end else begin
      //********************************************************************
      // Status, two cycles behind the strobe
      //********************************************************************
      if (ev2[2] && exp_wr != '1) exp_wr = exp_wr + 1'b1;
      if (ev2[1] && exp_rd != '1) exp_rd = exp_rd + 1'b1;
      if (ev2[0] && exp_mm != '1) exp_mm = exp_mm + 1'b1;
      if (|ev2) exp_cmp = 1'b1;
      check_val("compare_error", id2, 256'(exp_cmp), 256'(compare_error_i));
      check_val("err_wr_cnt", id2, 256'(exp_wr), 256'(err_wr_cnt_i));
      check_val("err_rd_cnt", id2, 256'(exp_rd), 256'(err_rd_cnt_i));
      check_val("err_mm_cnt", id2, 256'(exp_mm), 256'(err_mm_cnt_i));

      //********************************************************************
      // Upsized words leaving the chain
      //********************************************************************
      if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
        check_val("mem_valid", exp_q[0].id, 256'(1'b1), 256'(mem_valid_i));
        check_val("mem_word", exp_q[0].id, 256'(exp_q[0].word), 256'(mem_word_i));
        void'(exp_q.pop_front());
      end else if (mem_valid_i) begin
        errors++;
        $display("Unexpected word on mem_valid_o in cycle %0d", cyc);
      end

      // Inputs seen here are taken at the next rising edge
      ev2 = ev1;
      id2 = id1;
      ev1 = {wr_valid_i && !calib_done_i, rd_valid_i && !calib_done_i,
             rd_valid_i && calib_done_i && (rd_i.rdata != rd_i.expected)};
      id1 = test_id_i;
      if (wr_valid_i && calib_done_i) begin
        ent.due = cyc + `DDR_SLICE_DEPTH + 1;
        ent.id  = test_id_i;
        if (half) begin
          ent.word.data = {wr_beat_i.data, lo.data};
          ent.word.strb = {wr_beat_i.strb, lo.strb};
          exp_q.push_back(ent);
          half = 1'b0;
        end else if (wr_beat_i.last) begin
          ent.word.data = {64'h0, wr_beat_i.data};
          ent.word.strb = {8'h00, wr_beat_i.strb};
          exp_q.push_back(ent);
        end else begin
          lo   = wr_beat_i;
          half = 1'b1;
        end
      end
      cyc = cyc + 1;
    end
    pending = exp_q.size();
  end

endmodule

//--- hdl/ddr_bridge_top.sv
//**************************************************************************
// DDR bridge data path top
//**************************************************************************
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module ddr_bridge_top (
  input  logic                         c0_ddr4_clk,
  input  logic                         reset_i,
  input  logic                         calib_done_i,
  input  logic                         wr_valid_i,
  input  ddr_bridge_pkg::narrow_beat_t wr_beat_i,
  input  logic                         rd_valid_i,
  input  ddr_bridge_pkg::rd_check_t    rd_i,
  output logic                         mem_valid_o,
  output ddr_bridge_pkg::wide_word_t   mem_word_o,
  output logic                         compare_error_o,
  output ddr_bridge_pkg::err_cnt_t     err_wr_cnt_o,
  output ddr_bridge_pkg::err_cnt_t     err_rd_cnt_o,
  output ddr_bridge_pkg::err_cnt_t     err_mm_cnt_o
);
  import ddr_bridge_pkg::*;

  logic       wide_valid;
  wide_word_t wide_word;
  logic       write_err;
  logic       read_err;
  logic       mismatch;

  //************************************************************************
  // Write path
  //************************************************************************
  wr_upsizer u_wr_upsizer (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .reset_i      (reset_i),
    .calib_done_i (calib_done_i),
    .valid_i      (wr_valid_i),
    .beat_i       (wr_beat_i),
    .valid_o      (wide_valid),
    .word_o       (wide_word),
    .write_err_o  (write_err)
  );

  reg_slice_chain #(
    .DEPTH (`DDR_SLICE_DEPTH)
  ) u_slice_chain (
    .c0_ddr4_clk (c0_ddr4_clk),
    .reset_i     (reset_i),
    .valid_i     (wide_valid),
    .word_i      (wide_word),
    .valid_o     (mem_valid_o),
    .word_o      (mem_word_o)
  );

  //************************************************************************
  // Read check and status
  //************************************************************************
  rd_checker u_rd_checker (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .reset_i      (reset_i),
    .calib_done_i (calib_done_i),
    .rd_valid_i   (rd_valid_i),
    .rd_i         (rd_i),
    .mismatch_o   (mismatch),
    .read_err_o   (read_err)
  );

  ddr_status u_status (
    .c0_ddr4_clk     (c0_ddr4_clk),
    .reset_i         (reset_i),
    .write_err_i     (write_err),
    .read_err_i      (read_err),
    .mismatch_i      (mismatch),
    .compare_error_o (compare_error_o),
    .wr_cnt_o        (err_wr_cnt_o),
    .rd_cnt_o        (err_rd_cnt_o),
    .mm_cnt_o        (err_mm_cnt_o)
  );

endmodule

//--- hdl/ddr_status.sv
//**************************************************************************
// Compare error status
//**************************************************************************
`timescale 1ns/100ps

module ddr_status (
  input  logic                     c0_ddr4_clk,
  input  logic                     reset_i,
  input  logic                     write_err_i,
  input  logic                     read_err_i,
  input  logic                     mismatch_i,
  output logic                     compare_error_o,
  output ddr_bridge_pkg::err_cnt_t wr_cnt_o,
  output ddr_bridge_pkg::err_cnt_t rd_cnt_o,
  output ddr_bridge_pkg::err_cnt_t mm_cnt_o
);
  import ddr_bridge_pkg::*;

  // Counter holds at all ones
  function automatic err_cnt_t sat_inc(input err_cnt_t cnt);
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      compare_error_o <= 1'b0;
      wr_cnt_o        <= '0;
      rd_cnt_o        <= '0;
      mm_cnt_o        <= '0;
    end else begin
      // Combined flag, cleared only by reset
      if (write_err_i || read_err_i || mismatch_i) begin
        compare_error_o <= 1'b1;
      end
      if (write_err_i) begin
        wr_cnt_o <= sat_inc(wr_cnt_o);
      end
      if (read_err_i) begin
        rd_cnt_o <= sat_inc(rd_cnt_o);
      end
      if (mismatch_i) begin
        mm_cnt_o <= sat_inc(mm_cnt_o);
      end
    end
  end

endmodule

//--- hdl/rd_checker.sv
//**************************************************************************
// Read data checker
//**************************************************************************
`timescale 1ns/100ps

module rd_checker (
  input  logic                      c0_ddr4_clk,
  input  logic                      reset_i,
  input  logic                      calib_done_i,
  input  logic                      rd_valid_i,
  input  ddr_bridge_pkg::rd_check_t rd_i,
  output logic                      mismatch_o,
  output logic                      read_err_o
);

  logic data_diff;
  logic early_rd;
  logic late_rd;

  // Any bit differing counts as a mismatch
  assign data_diff = (rd_i.rdata != rd_i.expected);

  // Read returned while the controller is not yet calibrated
  assign early_rd = rd_valid_i && !calib_done_i;
  assign late_rd  = rd_valid_i && calib_done_i;

  //************************************************************************
  // Classification
  //************************************************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      mismatch_o <= 1'b0;
      read_err_o <= 1'b0;
    end else begin
      mismatch_o <= late_rd && data_diff;
      read_err_o <= early_rd;
    end
  end

  // Pulses only follow a read strobe, and never both at once
  a_one_cause_per_read: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    (mismatch_o || read_err_o) |->
      $past(rd_valid_i) && $onehot0({mismatch_o, read_err_o})
  );

endmodule

//--- hdl/reg_slice_chain.sv
//**************************************************************************
// Register cut chain for upsized words
//**************************************************************************
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module reg_slice_chain #(
  parameter int DEPTH = `DDR_SLICE_DEPTH
) (
  input  logic                       c0_ddr4_clk,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  ddr_bridge_pkg::wide_word_t word_i,
  output logic                       valid_o,
  output ddr_bridge_pkg::wide_word_t word_o
);
  import ddr_bridge_pkg::*;

  logic       vld_q  [DEPTH];
  wide_word_t word_q [DEPTH];

  // Valid bits shift every cycle, one slot per cut
  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    word_q[0] <= word_i;
    for (int i = 1; i < DEPTH; i++) begin
      word_q[i] <= word_q[i-1];
    end
  end

  assign valid_o = vld_q[DEPTH-1];
  assign word_o  = word_q[DEPTH-1];

  // Every word that enters leaves exactly DEPTH cycles later, none appear
  a_chain_latency: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    ##DEPTH (valid_o == $past(valid_i, DEPTH))
  );

endmodule

//--- hdl/wr_upsizer.sv
//**************************************************************************
// Write data upsizer, 64 to 128 bits
//**************************************************************************
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module wr_upsizer (
  input  logic                         c0_ddr4_clk,
  input  logic                         reset_i,
  input  logic                         calib_done_i,
  input  logic                         valid_i,
  input  ddr_bridge_pkg::narrow_beat_t beat_i,
  output logic                         valid_o,
  output ddr_bridge_pkg::wide_word_t   word_o,
  output logic                         write_err_o
);
  import ddr_bridge_pkg::*;

  localparam int HALF_STRB = `DDR_NARROW_W / 8;

  ups_state_e               state_q;
  logic [`DDR_NARROW_W-1:0] lo_data_q;
  logic [HALF_STRB-1:0]     lo_strb_q;
  logic                     take;
  logic                     emit;

  // Beats before calibration are dropped
  assign take = valid_i && calib_done_i;

  // Second beat of a pair completes the word, a last beat flushes a lone half
  assign emit = take && (state_q == UPS_HALF || beat_i.last);

  always_ff @(posedge c0_ddr4_clk) begin
    if (reset_i) begin
      state_q     <= UPS_EMPTY;
      valid_o     <= 1'b0;
      write_err_o <= 1'b0;
    end else begin
      valid_o     <= emit;
      write_err_o <= valid_i && !calib_done_i;
      if (take) begin
        if (state_q == UPS_EMPTY && !beat_i.last) begin
          state_q <= UPS_HALF;
        end else begin
          state_q <= UPS_EMPTY;
        end
      end
    end
  end

  // Lower half store and output word
  always_ff @(posedge c0_ddr4_clk) begin
    if (take && state_q == UPS_EMPTY) begin
      lo_data_q <= beat_i.data;
      lo_strb_q <= beat_i.strb;
    end
    if (emit) begin
      if (state_q == UPS_HALF) begin
        word_o.data <= {beat_i.data, lo_data_q};
        word_o.strb <= {beat_i.strb, lo_strb_q};
      end else begin
        // Single beat burst, upper half stays empty
        word_o.data <= {{`DDR_NARROW_W{1'b0}}, beat_i.data};
        word_o.strb <= {{HALF_STRB{1'b0}}, beat_i.strb};
      end
    end
  end

  // A pending half never sees two words leave back to back
  a_half_no_double_emit: assert property (
    @(posedge c0_ddr4_clk) disable iff (reset_i)
    (state_q == UPS_HALF) |-> !(valid_o && $past(valid_o))
  );

endmodule

//--- hdl/ddr_bridge_pkg.sv
//**************************************************************************
// DDR bridge shared types
//**************************************************************************
`include "ddr_bridge_cfg.svh"

package ddr_bridge_pkg;

  //************************************************************************
  // Write path
  //************************************************************************

  // One system side write beat
  typedef struct packed {
    logic [`DDR_NARROW_W-1:0]   data;
    logic [`DDR_NARROW_W/8-1:0] strb;
    logic                       last;
  } narrow_beat_t;

  // Upsized word as handed to the controller
  typedef struct packed {
    logic [`DDR_WIDE_W-1:0]   data;
    logic [`DDR_WIDE_W/8-1:0] strb;
  } wide_word_t;

  // Upsizer holds either nothing or the lower half of a word
  typedef enum logic {
    UPS_EMPTY = 1'b0,
    UPS_HALF  = 1'b1
  } ups_state_e;

  //************************************************************************
  // Read check and status
  //************************************************************************

  // Read return together with the data it should carry
  typedef struct packed {
    logic [`DDR_WIDE_W-1:0] rdata;
    logic [`DDR_WIDE_W-1:0] expected;
  } rd_check_t;

  typedef logic [`DDR_ERRCNT_W-1:0] err_cnt_t;

endpackage

//--- include/ddr_bridge_cfg.svh
//**************************************************************************
// DDR bridge configuration
//**************************************************************************
`ifndef DDR_BRIDGE_CFG_SVH
`define DDR_BRIDGE_CFG_SVH

// System bus side data width
`define DDR_NARROW_W 64

// DDR4 controller port data width
`define DDR_WIDE_W 128

// Register cuts between the upsizer and the controller
`define DDR_SLICE_DEPTH 6

// Saturating error counters
`define DDR_ERRCNT_W 8

`endif
